// ==== hdl/opd_pkg.sv ====
/*
 * Shared types for the opcode decoder and its prefetch pipe.
 * Only a reduced 68030 operation set is decoded; all else is ILLEGAL.
 * Enum encodings are internal and carry no architectural meaning.
 */

package opd_pkg;

    // ============================================================
    // Word and pipe geometry
    // ============================================================
    localparam int WORD_W     = 16; // Instruction word width.
    localparam int PIPE_DEPTH = 3;  // Words D, C and B.

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [1:0]        pntr_t; // Fill count 0 to 3.

    // Instruction length in words.
    typedef enum logic [1:0] {
        LVL_D = 2'd0, // One word.
        LVL_C = 2'd1, // Two words.
        LVL_B = 2'd2  // Three words.
    } instr_lvl_t;

    // ============================================================
    // Operations and trap codes
    // ============================================================
    typedef enum logic [3:0] {
        ORI,
        ANDI,
        SUBI,
        ADDI,
        MOVEQ,
        BRA,
        BSR,
        BCC,
        NOP,
        RTS,
        STOP,
        TRAP,
        ILLEGAL,
        UNIMPLEMENTED  // Line A and line F.
    } op_t;

    typedef enum logic [2:0] {
        T_NONE,
        T_1010,    // Line A emulator.
        T_1111,    // Line F emulator.
        T_ILLEGAL,
        T_TRAP,
        T_PRIV     // Privilege violation.
    } trap_t;

endpackage

// ==== hdl/opd_fetch_ctrl.sv ====
/*
 * Opcode fetch control. opcode_rd is a level, answered by a one cycle
 * opcode_rdy. A response in flight at a flush is dropped.
 */
`timescale 1ns/100ps

module opd_fetch_ctrl (
    input  logic           CLK,
    input  logic           reset,
    input  opd_pkg::pntr_t pntr,        // Current pipe fill.
    input  logic           ipipe_flush,
    input  logic           opcode_rdy,
    output logic           opcode_rd,
    output logic           word_valid   // Filtered write strobe to the pipe.
);
    import opd_pkg::*;

    logic rd_req;  // Read request register.
    logic discard; // Drop the next opcode_rdy.

    // Request a word whenever the pipe has room.
    always_ff @(posedge CLK) begin : rd_req_ff
        if (reset) begin
            rd_req <= 1'b0;
        end else if (opcode_rdy) begin
            rd_req <= 1'b0;            // Cycle done.
        end else if (ipipe_flush || discard) begin
            rd_req <= 1'b0;            // Let the flush settle first.
        end else if (pntr < PIPE_DEPTH) begin
            rd_req <= 1'b1;
        end
    end

    // Arm only with a read really outstanding, else nothing would clear it.
    always_ff @(posedge CLK) begin : discard_ff
        if (reset) begin
            discard <= 1'b0;
        end else if (ipipe_flush && rd_req && !opcode_rdy) begin
            discard <= 1'b1;
        end else if (opcode_rdy) begin
            discard <= 1'b0;           // Stale word is gone.
        end
    end

    assign opcode_rd  = rd_req && !opcode_rdy;               // Drops with the ready pulse.
    assign word_valid = opcode_rdy && !ipipe_flush && !discard;

endmodule

// ==== hdl/opd_ipipe.sv ====
/*
 * Three word instruction pipe, D is the oldest word.
 * ow_req and ew_req must never be high together.
 * The requester keeps the pipe aligned by asking for the right word count.
 */
`timescale 1ns/100ps

module opd_ipipe (
    input  logic               CLK,
    input  logic               reset,
    input  logic               ipipe_flush,
    input  logic               word_valid,  // Filtered opcode_rdy.
    input  opd_pkg::word_t     opcode_data,
    input  logic               ow_req,
    input  logic               ew_req,
    input  opd_pkg::instr_lvl_t lvl,        // Length of the word in D.
    output opd_pkg::word_t     ipipe_d,
    output opd_pkg::word_t     ipipe_c,
    output opd_pkg::word_t     ipipe_b,
    output opd_pkg::pntr_t     pntr,
    output logic               pipe_rdy
);
    import opd_pkg::*;

    word_t pipe_q   [PIPE_DEPTH]; // Index 0 is D.
    word_t pipe_nxt [PIPE_DEPTH];
    pntr_t pntr_nxt;
    pntr_t shift_n;               // Words consumed this cycle.
    pntr_t fill_n;                // Words left after the shift.

    // ============================================================
    // Readiness
    // ============================================================
    // Level D still needs C present, decode looks at two words.
    always_comb begin : rdy_calc
        pipe_rdy = 1'b0;
        if (ow_req) begin
            if (lvl == LVL_B) begin
                pipe_rdy = (pntr == 2'd3);
            end else begin
                pipe_rdy = (pntr >= 2'd2);
            end
        end else if (ew_req) begin
            pipe_rdy = (pntr >= 2'd1); // One word is enough.
        end
    end

    // ============================================================
    // Shift and refill
    // ============================================================
    always_comb begin : pipe_next
        shift_n = 2'd0;
        if (pipe_rdy) begin
            if (ow_req) begin
                case (lvl)
                    LVL_B:   shift_n = 2'd3;
                    LVL_C:   shift_n = 2'd2;
                    default: shift_n = 2'd1;
                endcase
            end else begin
                shift_n = 2'd1;            // Extension word.
            end
        end
        fill_n = pntr - shift_n;           // No underflow, pipe_rdy checked it.

        for (int i = 0; i < PIPE_DEPTH; i++) begin
            if (i + int'(shift_n) < PIPE_DEPTH) begin
                pipe_nxt[i] = pipe_q[i + int'(shift_n)];
            end else begin
                pipe_nxt[i] = pipe_q[i];   // Slot is free, contents unused.
            end
        end

        // A new word lands behind whatever remains.
        if (word_valid && fill_n < PIPE_DEPTH) begin
            pipe_nxt[fill_n] = opcode_data;
            pntr_nxt         = fill_n + 2'd1;
        end else begin
            pntr_nxt = fill_n;
        end
    end

    always_ff @(posedge CLK) begin : pntr_ff
        if (reset || ipipe_flush) begin
            pntr <= 2'd0;                  // Flush empties the pipe.
        end else begin
            pntr <= pntr_nxt;
        end
    end

    always_ff @(posedge CLK) begin : words_ff
        for (int i = 0; i < PIPE_DEPTH; i++) begin
            pipe_q[i] <= pipe_nxt[i];
        end
    end

    assign ipipe_d = pipe_q[0];
    assign ipipe_c = pipe_q[1];
    assign ipipe_b = pipe_q[2];

endmodule

// ==== hdl/opd_op_decode.sv ====
/*
 * Combinational decode of the D word. Reduced operation set only,
 * every other pattern is ILLEGAL. Lines A and F are UNIMPLEMENTED.
 * STOP in user mode reports T_PRIV but is still acknowledged.
 */
`timescale 1ns/100ps

module opd_op_decode (
    input  opd_pkg::word_t      ipipe_d,
    input  logic                sbit,   // Supervisor state.
    output opd_pkg::op_t        op,
    output opd_pkg::instr_lvl_t lvl,
    output opd_pkg::trap_t      trap
);
    import opd_pkg::*;

    logic [3:0] line;  // Opcode line, bits 15 to 12.
    logic [1:0] size;  // Size field of the immediates.
    logic [7:0] disp;  // Branch byte displacement.

    assign line = ipipe_d[15:12];
    assign size = ipipe_d[7:6];
    assign disp = ipipe_d[7:0];

    // ============================================================
    // Operation
    // ============================================================
    always_comb begin : op_dec
        op = ILLEGAL;
        case (line)
            4'h0: begin
                if (size != 2'b11) begin   // Size 11 is not an immediate.
                    case (ipipe_d[11:8])
                        4'h0:    op = ORI;
                        4'h2:    op = ANDI;
                        4'h4:    op = SUBI;
                        4'h6:    op = ADDI;
                        default: op = ILLEGAL;
                    endcase
                end
            end
            4'h4: begin
                case (ipipe_d[11:0])
                    12'hE71: op = NOP;
                    12'hE72: op = STOP;
                    12'hE75: op = RTS;
                    default: begin
                        if (ipipe_d[11:4] == 8'hE4) begin
                            op = TRAP;     // Vector in bits 3 to 0.
                        end
                    end
                endcase
            end
            4'h6: begin
                case (ipipe_d[11:8])
                    4'h0:    op = BRA;
                    4'h1:    op = BSR;
                    default: op = BCC;
                endcase
            end
            4'h7: begin
                if (!ipipe_d[8]) begin
                    op = MOVEQ;
                end
            end
            4'hA, 4'hF: op = UNIMPLEMENTED;
            default:    op = ILLEGAL;
        endcase
    end

    // ============================================================
    // Length and trap
    // ============================================================
    always_comb begin : lvl_dec
        lvl = LVL_D;
        case (op)
            ORI, ANDI, SUBI, ADDI: lvl = (size == 2'b10) ? LVL_B : LVL_C; // Long takes two words.
            BRA, BSR, BCC: begin
                if (disp == 8'h00) begin
                    lvl = LVL_C;           // 16 bit displacement.
                end else if (disp == 8'hFF) begin
                    lvl = LVL_B;           // 32 bit displacement.
                end
            end
            STOP:    lvl = LVL_C;          // Immediate SR word.
            default: lvl = LVL_D;
        endcase
    end

    always_comb begin : trap_dec
        trap = T_NONE;
        if (op == UNIMPLEMENTED) begin
            trap = (line == 4'hA) ? T_1010 : T_1111;
        end else if (op == ILLEGAL) begin
            trap = T_ILLEGAL;
        end else if (op == TRAP) begin
            trap = T_TRAP;
        end else if (op == STOP && !sbit) begin
            trap = T_PRIV;
        end
    end

endmodule

// ==== hdl/opd_out_regs.sv ====
/*
 * Output registers and acknowledges. ow_ack and ew_ack are single cycle.
 * A flush cancels an acceptance in the same cycle.
 */
`timescale 1ns/100ps

module opd_out_regs (
    input  logic           CLK,
    input  logic           reset,
    input  logic           ipipe_flush,
    input  logic           ow_req,
    input  logic           ew_req,
    input  logic           pipe_rdy,
    input  opd_pkg::word_t ipipe_d,
    input  opd_pkg::word_t ipipe_c,
    input  opd_pkg::word_t ipipe_b,
    input  opd_pkg::op_t   op_in,
    input  opd_pkg::trap_t trap_in,
    output logic           ow_ack,
    output logic           ew_ack,
    output opd_pkg::op_t   op,
    output opd_pkg::trap_t trap_code,
    output opd_pkg::word_t biw_0,
    output opd_pkg::word_t biw_1,
    output opd_pkg::word_t biw_2,
    output opd_pkg::word_t ext_word
);
    import opd_pkg::*;

    logic ow_accept; // Operation taken this edge.
    logic ew_accept; // Extension word taken this edge.

    assign ow_accept = ow_req && pipe_rdy && !ipipe_flush;
    assign ew_accept = ew_req && pipe_rdy && !ipipe_flush;

    // ============================================================
    // Control
    // ============================================================
    always_ff @(posedge CLK) begin : ctrl_ff
        if (reset) begin
            ow_ack    <= 1'b0;
            ew_ack    <= 1'b0;
            op        <= NOP;
            trap_code <= T_NONE;
        end else begin
            ow_ack <= ow_accept;
            ew_ack <= ew_accept;
            if (ipipe_flush) begin
                trap_code <= T_NONE;
            end else if (ow_accept) begin
                op        <= op_in;
                trap_code <= trap_in;   // Privilege trap travels with the ack.
            end
        end
    end

    // Payload words. BIW_1 and BIW_2 load even when the level leaves them unused.
    always_ff @(posedge CLK) begin : data_ff
        if (ow_accept) begin
            biw_0 <= ipipe_d;
            biw_1 <= ipipe_c;
            biw_2 <= ipipe_b;
        end
        if (ew_accept) begin
            ext_word <= ipipe_d;
        end
    end

endmodule

// ==== hdl/opcode_decoder.sv ====
/*
 * Opcode decoder with three word prefetch, first CPU pipeline stage.
 * Raise ow_req and drop it on ow_ack; ew_req likewise with ew_ack.
 * Never raise ow_req and ew_req together.
 */
`timescale 1ns/100ps

module opcode_decoder (
    input  logic           CLK,
    input  logic           reset,
    output logic           opcode_rd,
    input  logic           opcode_rdy,
    input  opd_pkg::word_t opcode_data,
    input  logic           ipipe_flush,
    input  logic           ow_req,
    input  logic           ew_req,
    input  logic           sbit,
    output logic           ow_ack,
    output logic           ew_ack,
    output opd_pkg::op_t   op,
    output opd_pkg::trap_t trap_code,
    output opd_pkg::word_t biw_0,
    output opd_pkg::word_t biw_1,
    output opd_pkg::word_t biw_2,
    output opd_pkg::word_t ext_word
);
    import opd_pkg::*;

    // ============================================================
    // Internal wires
    // ============================================================
    logic       word_valid;
    logic       pipe_rdy;
    pntr_t      pntr;
    word_t      ipipe_d;
    word_t      ipipe_c;
    word_t      ipipe_b;
    op_t        dec_op;   // Decode of the current D word.
    instr_lvl_t dec_lvl;
    trap_t      dec_trap;

    opd_fetch_ctrl opd_fetch_ctrl_i (
        .CLK         (CLK),
        .reset       (reset),
        .pntr        (pntr),
        .ipipe_flush (ipipe_flush),
        .opcode_rdy  (opcode_rdy),
        .opcode_rd   (opcode_rd),
        .word_valid  (word_valid)
    );

    opd_ipipe opd_ipipe_i (
        .CLK         (CLK),
        .reset       (reset),
        .ipipe_flush (ipipe_flush),
        .word_valid  (word_valid),
        .opcode_data (opcode_data),
        .ow_req      (ow_req),
        .ew_req      (ew_req),
        .lvl         (dec_lvl),
        .ipipe_d     (ipipe_d),
        .ipipe_c     (ipipe_c),
        .ipipe_b     (ipipe_b),
        .pntr        (pntr),
        .pipe_rdy    (pipe_rdy)
    );

    opd_op_decode opd_op_decode_i (
        .ipipe_d (ipipe_d),
        .sbit    (sbit),
        .op      (dec_op),
        .lvl     (dec_lvl),
        .trap    (dec_trap)
    );

    opd_out_regs opd_out_regs_i (
        .CLK         (CLK),
        .reset       (reset),
        .ipipe_flush (ipipe_flush),
        .ow_req      (ow_req),
        .ew_req      (ew_req),
        .pipe_rdy    (pipe_rdy),
        .ipipe_d     (ipipe_d),
        .ipipe_c     (ipipe_c),
        .ipipe_b     (ipipe_b),
        .op_in       (dec_op),
        .trap_in     (dec_trap),
        .ow_ack      (ow_ack),
        .ew_ack      (ew_ack),
        .op          (op),
        .trap_code   (trap_code),
        .biw_0       (biw_0),
        .biw_1       (biw_1),
        .biw_2       (biw_2),
        .ext_word    (ext_word)
    );

endmodule

// ==== include/opd_tb_model.svh ====
/*
 * Reference model for the opcode decoder testbench. Included in the
 * testbench module body; it uses the module's mem array and lists.
 * Opcode rules follow the reduced 68030 set, all else is ILLEGAL.
 */
`ifndef OPD_TB_MODEL_SVH
`define OPD_TB_MODEL_SVH

// Expected op, trap and word count of one instruction word.
function automatic void predict(input word_t w, input logic s, output op_t p_op,
                                output trap_t p_trap, output int len);
    p_op   = ILLEGAL;
    p_trap = T_NONE;
    len    = 1;
    if (w[15:12] == 4'h0 && !w[11] && !w[8] && w[7:6] != 2'b11) begin
        case (w[10:9])                          // Bits 11 to 8 of 0, 2, 4, 6.
            2'd0:    p_op = ORI;
            2'd1:    p_op = ANDI;
            2'd2:    p_op = SUBI;
            default: p_op = ADDI;
        endcase
        len = (w[7:6] == 2'b10) ? 3 : 2;        // Long immediate is two words.
    end else if (w[15:12] == 4'h7 && !w[8]) begin
        p_op = MOVEQ;
    end else if (w[15:12] == 4'h6) begin
        case (w[11:8])
            4'h0:    p_op = BRA;
            4'h1:    p_op = BSR;
            default: p_op = BCC;
        endcase
        if (w[7:0] == 8'h00) begin
            len = 2;                            // Word displacement follows.
        end else if (w[7:0] == 8'hFF) begin
            len = 3;                            // Long displacement follows.
        end
    end else if (w == 16'h4E71) begin
        p_op = NOP;
    end else if (w == 16'h4E75) begin
        p_op = RTS;
    end else if (w == 16'h4E72) begin
        p_op   = STOP;
        len    = 2;
        p_trap = s ? T_NONE : T_PRIV;           // User mode STOP.
    end else if (w[15:4] == 12'h4E4) begin
        p_op   = TRAP;
        p_trap = T_TRAP;
    end else if (w[15:12] == 4'hA || w[15:12] == 4'hF) begin
        p_op   = UNIMPLEMENTED;
        p_trap = (w[15:12] == 4'hA) ? T_1010 : T_1111;
    end else begin
        p_trap = T_ILLEGAL;
    end
endfunction

// Random opcode, weighted toward the decoded set.
function automatic word_t random_instr();
    word_t r;
    r = word_t'($urandom);
    case ($urandom % 10)
        0: return {4'h0, 1'b0, r[1:0], 1'b0, (r[3:2] == 2'b11) ? 2'b10 : r[3:2], r[5:0]};
        1: return {4'h7, r[11:9], 1'b0, r[7:0]};        // MOVEQ.
        2: return {4'h6, r[11:8], 8'h00};
        3: return {4'h6, r[11:8], 8'hFF};
        4: return {4'h6, r[11:0]};                      // Byte branch, mostly.
        5: begin
            case (r[13:12])
                2'd0:    return 16'h4E71;
                2'd1:    return 16'h4E75;
                2'd2:    return 16'h4E72;
                default: return {12'h4E4, r[7:4]};      // TRAP #n.
            endcase
        end
        6: return {4'hA, r[11:0]};
        7: return {4'hF, r[11:0]};
        8: return 16'h4E72;                             // Extra STOPs for sbit.
        default: return r;
    endcase
endfunction

// Lays out n instructions from base, with their extension words.
// Some get one or two trailing data words, read later through ew_req.
task automatic build_stream(input int base, input int n);
    int    a;
    int    len;
    int    n_data;
    word_t w;
    op_t   p_op;
    trap_t p_trap;
    a = base;
    for (int i = 0; i < n; i++) begin
        w = random_instr();
        predict(w, 1'b1, p_op, p_trap, len);
        n_data = (($urandom % 4) == 0) ? 1 + ($urandom % 2) : 0;
        mem[a] = w;
        for (int k = 1; k < len + n_data; k++) begin
            mem[a + k] = word_t'($urandom);
        end
        ins_addr.push_back(a);
        ins_data.push_back(n_data);
        a += len + n_data;
    end
endtask

`endif

// ==== tb/tb_opcode_decoder.sv ====
/*
 * Testbench for the opcode decoder. A memory answers opcode reads with
 * 0 to 3 cycles of latency; the requester walks three streams and flushes
 * the pipe before the second (random point) and third (read in flight).
 */
`timescale 1ns/100ps

module tb_opcode_decoder;
    import opd_pkg::*;

    localparam int SEED      = 32'h7fb3_f106;
    localparam int N_SEG     = 3;
    localparam int SEG_INSTR = 105;     // 315 instructions in all.
    localparam int SEG_BASE  = 1024;    // Word spacing of the streams.
    localparam int MEM_WORDS = 4096;
    localparam int TIMEOUT   = 40 * N_SEG * SEG_INSTR + 200;

    logic  CLK = 1'b0;
    logic  reset;
    logic  opcode_rd;
    logic  opcode_rdy;
    word_t opcode_data;
    logic  ipipe_flush;
    logic  ow_req;
    logic  ew_req;
    logic  sbit;
    logic  ow_ack;
    logic  ew_ack;
    op_t   op;
    trap_t trap_code;
    word_t biw_0;
    word_t biw_1;
    word_t biw_2;
    word_t ext_word;

    word_t mem [MEM_WORDS];
    int    ins_addr [$];     // Start address of each instruction.
    int    ins_data [$];     // Data words read by ew_req after it.
    int    fetch_idx;        // Next address the memory hands out.
    int    flush_gen;        // Bumped when a flush is driven.
    logic  rd_busy;          // Memory holds an unanswered read.
    int    delivered;        // Words written since the last flush.
    int    consumed;         // Words taken since the last flush.
    int    errors;
    int    checks;
    int    cycles = 0;

    `include "opd_tb_model.svh"

    opcode_decoder opcode_decoder_i (.*);

    always #5 CLK = ~CLK;    // 10 ns period.

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_op(input op_t got, input op_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: instr %0d op %s, expected %s", $time, idx, got.name(), exp.name());
        end
    endtask

    task automatic check_trap(input trap_t got, input trap_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: instr %0d trap %s, expected %s", $time, idx, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what,
                              input int idx);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: instr %0d %s %h, expected %h", $time, idx, what, got, exp);
        end
    endtask

    // ============================================================
    // Memory and monitors
    // ============================================================
    always begin : memory_responder
        int   addr;
        int   gen;
        logic stale;
        @(negedge CLK);
        if (opcode_rd === 1'b1) begin
            addr    = fetch_idx;
            gen     = flush_gen;
            stale   = ipipe_flush;           // Asked during the flush cycle.
            rd_busy = 1'b1;
            fetch_idx++;
            @(posedge CLK);
            repeat ($urandom % 4) @(posedge CLK);
            #1;
            opcode_rdy  = 1'b1;
            opcode_data = mem[addr];
            @(negedge CLK);
            stale   = stale || ipipe_flush || (gen != flush_gen);
            rd_busy = 1'b0;
            @(posedge CLK);
            #1;
            opcode_rdy = 1'b0;
            if (!stale) begin
                delivered++;                 // DUT took the word.
            end
        end
    end

    // A full pipe must not request.
    always @(negedge CLK) begin : full_pipe_monitor
        if (!reset && opcode_rd && (delivered - consumed) >= PIPE_DEPTH) begin
            errors++;
            $display("opcode_rd was high at %0t while the pipe held three words", $time);
        end
    end

    always @(posedge CLK) begin : watchdog
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, an acknowledge never came", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ============================================================
    // Requester
    // ============================================================
    task automatic step();
        @(posedge CLK);
        #1;                                  // Drive and sample after the edge.
    endtask

    task automatic run_instr(input int i);
        op_t   p_op;
        trap_t p_trap;
        int    len;
        int    a;
        logic  s;
        a = ins_addr[i];
        s = 1'($urandom % 2);
        predict(mem[a], s, p_op, p_trap, len);
        sbit   = s;
        ow_req = 1'b1;
        do begin
            step();
        end while (!ow_ack);
        ow_req    = 1'b0;
        consumed += len;
        check_op(op, p_op, i);
        check_trap(trap_code, p_trap, i);
        check_word(biw_0, mem[a], "biw_0", i);
        check_word(biw_1, mem[a + 1], "biw_1", i);   // C is present at every level.
        if (len == 3) begin
            check_word(biw_2, mem[a + 2], "biw_2", i);
        end
        for (int k = 0; k < ins_data[i]; k++) begin
            ew_req = 1'b1;
            do begin
                step();
            end while (!ew_ack);
            ew_req = 1'b0;
            consumed++;
            check_word(ext_word, mem[a + len + k], "ext_word", i);
        end
    endtask

    task automatic flush_pipe(input int base, input logic in_flight);
        if (in_flight) begin
            while (!rd_busy) begin
                step();
            end
        end else begin
            repeat ($urandom % 4) step();
        end
        ipipe_flush = 1'b1;
        flush_gen++;
        step();
        ipipe_flush = 1'b0;
        check_trap(trap_code, T_NONE, -1);   // Flush clears the trap code.
        fetch_idx   = base;                  // Jump to the new stream.
        delivered   = 0;
        consumed    = 0;
    endtask

    initial begin : stimulus
        void'($urandom(SEED));
        reset       = 1'b1;
        opcode_rdy  = 1'b0;
        opcode_data = '0;
        ipipe_flush = 1'b0;
        ow_req      = 1'b0;
        ew_req      = 1'b0;
        sbit        = 1'b0;
        rd_busy     = 1'b0;
        fetch_idx   = 0;
        flush_gen   = 0;
        delivered   = 0;
        consumed    = 0;
        errors      = 0;
        checks      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_t'(i * 40503);     // Odd multiplier, unique per address.
        end
        for (int seg = 0; seg < N_SEG; seg++) begin
            build_stream(seg * SEG_BASE, SEG_INSTR);
        end
        repeat (10) @(posedge CLK);
        #1;
        reset = 1'b0;
        check_op(op, NOP, -1);
        check_trap(trap_code, T_NONE, -1);
        for (int seg = 0; seg < N_SEG; seg++) begin
            if (seg > 0) begin
                flush_pipe(seg * SEG_BASE, seg == 2);
            end
            for (int i = seg * SEG_INSTR; i < (seg + 1) * SEG_INSTR; i++) begin
                run_instr(i);
            end
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hdl/opd_pkg.sv
hdl/opd_fetch_ctrl.sv
hdl/opd_ipipe.sv
hdl/opd_op_decode.sv
hdl/opd_out_regs.sv
hdl/opcode_decoder.sv
tb/tb_opcode_decoder.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_opcode_decoder -f sources.f &&
./obj_dir/Vtb_opcode_decoder | tee sim.log &&
! grep -q "TEST RESULT: FAIL" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
